// File: common/cluster_config.svh
// configuration macros for core count, id width, boot addresses, event widths and address slots
`ifndef CLUSTER_CONFIG_SVH
`define CLUSTER_CONFIG_SVH

// cluster size and bus id width
`define NB_CORES 4
`define ID_WIDTH 5

// boot addresses, the rom one is used for standalone boot
`define BOOT_ADDR 32'h1C000000
`define ROM_BOOT_ADDR 32'h1A000000

// event widths
`define SOC_EVT_WIDTH 8
`define NB_EVENTS 3

// peripheral slots, decoded from address bits 11:8
`define TGT_CTRL 4'd0
`define TGT_TIMER 4'd1
`define TGT_EU 4'd2

`endif

// File: common/periph_bus_pkg.sv
// peripheral bus request and response types, target enumeration and byte-enable merge
`default_nettype none
`include "cluster_config.svh"

package periph_bus_pkg;

  // wen low means write
  typedef struct packed {
    logic [31:0]          add;
    logic                 wen;
    logic [31:0]          wdata;
    logic [3:0]           be;
    logic [`ID_WIDTH-1:0] id;
  } periph_req_t;

  // opc high flags an error
  typedef struct packed {
    logic [31:0]          rdata;
    logic                 opc;
    logic [`ID_WIDTH-1:0] id;
  } periph_resp_t;

  typedef enum logic [1:0] {CTRL, TIMER, EU, NONE} periph_target_e;

  // keeps the bytes of old_word whose be bit is clear
  function automatic logic [31:0] be_merge(input logic [31:0] old_word,
                                           input logic [31:0] new_word,
                                           input logic [3:0]  be);
    logic [31:0] res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = be[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: common/cluster_event_pkg.sv
// event source indices and per-core event vector type
`default_nettype none
`include "cluster_config.svh"

package cluster_event_pkg;

  // bit position of each source inside a core event vector
  typedef enum int unsigned {
    EVT_TIMER = 0,
    EVT_DMA   = 1,
    EVT_SOC   = 2
  } event_idx_e;

  // one bit per event line of a core
  typedef logic [`NB_EVENTS-1:0] core_evt_t;

endpackage

`default_nettype wire

// File: logic/pipe_reg.sv
// pipe_reg: single pipeline stage with typed payload and valid bit
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // payload only loads with a valid beat
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_o <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/speriph_router.sv
// speriph_router: target decode, select strobes and read data merge into a response
`timescale 1ns/100ps
`default_nettype none
`include "cluster_config.svh"

module speriph_router
  import periph_bus_pkg::*;
(
  input  logic         valid_i,
  input  periph_req_t  req_i,
  output logic         ctrl_sel_o,
  output logic         timer_sel_o,
  output logic         eu_sel_o,
  output logic [5:0]   offset_o,
  output logic         we_o,
  output logic [31:0]  wdata_o,
  output logic [3:0]   be_o,
  input  logic [31:0]  ctrl_rdata_i,
  input  logic [31:0]  timer_rdata_i,
  input  logic [31:0]  eu_rdata_i,
  output logic         resp_valid_o,
  output periph_resp_t resp_o
);

  periph_target_e target;
  logic [31:0]    sel_rdata;

  always_comb begin
    case (req_i.add[11:8])
      `TGT_CTRL:  target = CTRL;
      `TGT_TIMER: target = TIMER;
      `TGT_EU:    target = EU;
      default:    target = NONE;
    endcase
  end

  // at most one strobe, none for an unmapped slot
  assign ctrl_sel_o  = valid_i && (target == CTRL);
  assign timer_sel_o = valid_i && (target == TIMER);
  assign eu_sel_o    = valid_i && (target == EU);

  // shared word offset and write data for all peripherals
  assign offset_o = req_i.add[7:2];
  assign we_o     = ~req_i.wen;
  assign wdata_o  = req_i.wdata;
  assign be_o     = req_i.be;

  always_comb begin
    case (target)
      CTRL:    sel_rdata = ctrl_rdata_i;
      TIMER:   sel_rdata = timer_rdata_i;
      EU:      sel_rdata = eu_rdata_i;
      default: sel_rdata = '0;
    endcase
  end

  // sel_rdata is already zero for an unmapped slot
  assign resp_valid_o = valid_i;
  assign resp_o.id    = req_i.id;
  assign resp_o.opc   = (target == NONE);
  assign resp_o.rdata = req_i.wen ? sel_rdata : '0;

endmodule

`default_nettype wire

// File: control_unit/cluster_control_unit.sv
// cluster_control_unit: end of computation, fetch enable and boot address registers
`timescale 1ns/100ps
`default_nettype none
`include "cluster_config.svh"

module cluster_control_unit
  import periph_bus_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          sel_i,
  input  logic                          we_i,
  input  logic [5:0]                    offset_i,
  input  logic [31:0]                   wdata_i,
  input  logic [3:0]                    be_i,
  input  logic                          en_sa_boot_i,
  output logic [31:0]                   rdata_o,
  output logic                          eoc_o,
  output logic [`NB_CORES-1:0]          fetch_enable_o,
  output logic [`NB_CORES-1:0][31:0]    boot_addr_o
);

  logic                 eoc_q;
  logic [`NB_CORES-1:0] fetch_en_q;
  logic [31:0]          boot_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q      <= 1'b0;
      fetch_en_q <= '0;
      boot_q     <= `BOOT_ADDR;
    end else if (sel_i && we_i) begin
      case (offset_i)
        // eoc and fetch enable both sit in byte 0
        6'd0: if (be_i[0]) eoc_q <= wdata_i[0];
        6'd1: if (be_i[0]) fetch_en_q <= wdata_i[`NB_CORES-1:0];
        6'd2: boot_q <= be_merge(boot_q, wdata_i, be_i);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (offset_i)
      6'd0:    rdata_o = {31'b0, eoc_q};
      6'd1:    rdata_o = 32'(fetch_en_q);
      6'd2:    rdata_o = boot_q;
      default: rdata_o = '0;
    endcase
  end

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;

  // standalone boot forces every core to the rom
  for (genvar c = 0; c < `NB_CORES; c++) begin : g_boot_addr
    assign boot_addr_o[c] = en_sa_boot_i ? `ROM_BOOT_ADDR : boot_q;
  end

endmodule

`default_nettype wire

// File: timer/cluster_timer.sv
// cluster_timer: counter, compare and control registers with compare interrupt
`timescale 1ns/100ps
`default_nettype none

module cluster_timer
  import periph_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        sel_i,
  input  logic        we_i,
  input  logic [5:0]  offset_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  be_i,
  output logic [31:0] rdata_o,
  output logic        irq_o
);

  logic [31:0] count_q;
  logic [31:0] cmp_q;
  logic        en_q;
  logic        match;

  // one pulse per period of cmp_q + 1 cycles
  assign match = en_q && (count_q == cmp_q);
  assign irq_o = match;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q <= '0;
      cmp_q   <= '0;
      en_q    <= 1'b0;
    end else begin
      if (en_q) begin
        count_q <= match ? '0 : count_q + 32'd1;
      end
      // a bus write lands after the increment and wins
      if (sel_i && we_i) begin
        case (offset_i)
          6'd0: count_q <= be_merge(count_q, wdata_i, be_i);
          6'd1: cmp_q <= be_merge(cmp_q, wdata_i, be_i);
          6'd2: if (be_i[0]) en_q <= wdata_i[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (offset_i)
      6'd0:    rdata_o = count_q;
      6'd1:    rdata_o = cmp_q;
      6'd2:    rdata_o = {31'b0, en_q};
      default: rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: event_unit/event_unit.sv
// event_unit: pending and mask registers, interrupt request and id, acknowledge, clock enables
`timescale 1ns/100ps
`default_nettype none
`include "cluster_config.svh"

module event_unit
  import cluster_event_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          sel_i,
  input  logic                          we_i,
  input  logic [5:0]                    offset_i,
  input  logic [31:0]                   wdata_i,
  input  logic [3:0]                    be_i,
  output logic [31:0]                   rdata_o,
  input  logic                          timer_evt_i,
  input  logic [`NB_CORES-1:0]          dma_events_i,
  input  logic                          soc_evt_valid_i,
  input  logic [`SOC_EVT_WIDTH-1:0]     soc_evt_data_i,
  output logic [`NB_CORES-1:0]          irq_req_o,
  output logic [`NB_CORES-1:0][4:0]     irq_id_o,
  input  logic [`NB_CORES-1:0]          irq_ack_i,
  input  logic [`NB_CORES-1:0][4:0]     irq_ack_id_i,
  input  logic [`NB_CORES-1:0]          core_busy_i,
  output logic [`NB_CORES-1:0]          core_clk_en_o
);

  core_evt_t [`NB_CORES-1:0] mask_q;
  core_evt_t [`NB_CORES-1:0] pend_q;
  core_evt_t [`NB_CORES-1:0] evt_set;
  core_evt_t [`NB_CORES-1:0] evt_clr;
  core_evt_t [`NB_CORES-1:0] active;
  logic [`SOC_EVT_WIDTH-1:0] soc_data_q;
  logic                      bus_wr;

  // all event bits live in byte 0
  assign bus_wr = sel_i && we_i && be_i[0];

  always_comb begin
    for (int c = 0; c < `NB_CORES; c++) begin
      evt_set[c] = '0;
      evt_set[c][EVT_TIMER] = timer_evt_i;
      evt_set[c][EVT_DMA] = dma_events_i[c];
      evt_set[c][EVT_SOC] = soc_evt_valid_i;
      evt_clr[c] = '0;
      for (int e = 0; e < `NB_EVENTS; e++) begin
        if (irq_ack_i[c] && (irq_ack_id_i[c] == 5'(e))) begin
          evt_clr[c][e] = 1'b1;
        end
      end
      // write one to clear
      if (bus_wr && (offset_i == 6'(4 + c))) begin
        evt_clr[c] = evt_clr[c] | wdata_i[`NB_EVENTS-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q <= '0;
      pend_q <= '0;
    end else begin
      for (int c = 0; c < `NB_CORES; c++) begin
        // a new event beats a clear in the same cycle
        pend_q[c] <= (pend_q[c] & ~evt_clr[c]) | evt_set[c];
        if (bus_wr && (offset_i == 6'(c))) begin
          mask_q[c] <= wdata_i[`NB_EVENTS-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (soc_evt_valid_i) begin
      soc_data_q <= soc_evt_data_i;
    end
  end

  // lowest masked pending bit gives the id
  always_comb begin
    for (int c = 0; c < `NB_CORES; c++) begin
      active[c] = pend_q[c] & mask_q[c];
      irq_req_o[c] = |active[c];
      irq_id_o[c] = '0;
      for (int e = `NB_EVENTS - 1; e >= 0; e--) begin
        if (active[c][e]) begin
          irq_id_o[c] = 5'(e);
        end
      end
    end
  end

  assign core_clk_en_o = core_busy_i | irq_req_o;

  always_comb begin
    rdata_o = '0;
    if (offset_i < 6'd4) begin
      rdata_o = 32'(mask_q[offset_i[1:0]]);
    end else if (offset_i < 6'd8) begin
      rdata_o = 32'(pend_q[offset_i[1:0]]);
    end else if (offset_i == 6'd8) begin
      rdata_o = 32'(soc_data_q);
    end
  end

endmodule

`default_nettype wire

// File: logic/cluster_peripherals.sv
// cluster_peripherals: request stage, router, control unit, timer, event unit, response stage
`timescale 1ns/100ps
`default_nettype none
`include "cluster_config.svh"

module cluster_peripherals
  import periph_bus_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic                          req_i,
  input  logic [31:0]                   add_i,
  input  logic                          wen_i,
  input  logic [31:0]                   wdata_i,
  input  logic [3:0]                    be_i,
  input  logic [`ID_WIDTH-1:0]          id_i,
  output logic                          r_valid_o,
  output logic [31:0]                   r_rdata_o,
  output logic                          r_opc_o,
  output logic [`ID_WIDTH-1:0]          r_id_o,
  input  logic                          en_sa_boot_i,
  output logic                          eoc_o,
  output logic [`NB_CORES-1:0]          fetch_enable_o,
  output logic [`NB_CORES-1:0][31:0]    boot_addr_o,
  input  logic [`NB_CORES-1:0]          dma_events_i,
  input  logic                          soc_evt_valid_i,
  input  logic [`SOC_EVT_WIDTH-1:0]     soc_evt_data_i,
  output logic [`NB_CORES-1:0]          irq_req_o,
  output logic [`NB_CORES-1:0][4:0]     irq_id_o,
  input  logic [`NB_CORES-1:0]          irq_ack_i,
  input  logic [`NB_CORES-1:0][4:0]     irq_ack_id_i,
  input  logic [`NB_CORES-1:0]          core_busy_i,
  output logic [`NB_CORES-1:0]          core_clk_en_o
);

  periph_req_t  req_d;
  periph_req_t  req_q;
  logic         req_valid_q;
  periph_resp_t resp_d;
  periph_resp_t resp_q;
  logic         resp_valid_d;
  logic         ctrl_sel;
  logic         timer_sel;
  logic         eu_sel;
  logic [5:0]   offset;
  logic         we;
  logic [31:0]  wdata;
  logic [3:0]   be;
  logic [31:0]  ctrl_rdata;
  logic [31:0]  timer_rdata;
  logic [31:0]  eu_rdata;
  logic         timer_irq;

  assign req_d = '{add: add_i, wen: wen_i, wdata: wdata_i, be: be_i, id: id_i};

  pipe_reg #(.payload_t(periph_req_t)) req_stage_i (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .valid_i ( req_i       ),
    .data_i  ( req_d       ),
    .valid_o ( req_valid_q ),
    .data_o  ( req_q       )
  );

  speriph_router router_i (
    .valid_i       ( req_valid_q  ),
    .req_i         ( req_q        ),
    .ctrl_sel_o    ( ctrl_sel     ),
    .timer_sel_o   ( timer_sel    ),
    .eu_sel_o      ( eu_sel       ),
    .offset_o      ( offset       ),
    .we_o          ( we           ),
    .wdata_o       ( wdata        ),
    .be_o          ( be           ),
    .ctrl_rdata_i  ( ctrl_rdata   ),
    .timer_rdata_i ( timer_rdata  ),
    .eu_rdata_i    ( eu_rdata     ),
    .resp_valid_o  ( resp_valid_d ),
    .resp_o        ( resp_d       )
  );

  cluster_control_unit ctrl_unit_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .sel_i          ( ctrl_sel       ),
    .we_i           ( we             ),
    .offset_i       ( offset         ),
    .wdata_i        ( wdata          ),
    .be_i           ( be             ),
    .en_sa_boot_i   ( en_sa_boot_i   ),
    .rdata_o        ( ctrl_rdata     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer timer_i (
    .clk_i    ( clk_i       ),
    .rst_i    ( rst_i       ),
    .sel_i    ( timer_sel   ),
    .we_i     ( we          ),
    .offset_i ( offset      ),
    .wdata_i  ( wdata       ),
    .be_i     ( be          ),
    .rdata_o  ( timer_rdata ),
    .irq_o    ( timer_irq   )
  );

  // timer interrupt reaches every core as an event
  event_unit event_unit_i (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .sel_i           ( eu_sel          ),
    .we_i            ( we              ),
    .offset_i        ( offset          ),
    .wdata_i         ( wdata           ),
    .be_i            ( be              ),
    .rdata_o         ( eu_rdata        ),
    .timer_evt_i     ( timer_irq       ),
    .dma_events_i    ( dma_events_i    ),
    .soc_evt_valid_i ( soc_evt_valid_i ),
    .soc_evt_data_i  ( soc_evt_data_i  ),
    .irq_req_o       ( irq_req_o       ),
    .irq_id_o        ( irq_id_o        ),
    .irq_ack_i       ( irq_ack_i       ),
    .irq_ack_id_i    ( irq_ack_id_i    ),
    .core_busy_i     ( core_busy_i     ),
    .core_clk_en_o   ( core_clk_en_o   )
  );

  pipe_reg #(.payload_t(periph_resp_t)) resp_stage_i (
    .clk_i   ( clk_i        ),
    .rst_i   ( rst_i        ),
    .valid_i ( resp_valid_d ),
    .data_i  ( resp_d       ),
    .valid_o ( r_valid_o    ),
    .data_o  ( resp_q       )
  );

  assign r_rdata_o = resp_q.rdata;
  assign r_opc_o   = resp_q.opc;
  assign r_id_o    = resp_q.id;

endmodule

`default_nettype wire

// File: testbench/cluster_peripherals_asserts.sv
// concurrent assertions on response latency, interrupt id range and state after reset
`timescale 1ns/100ps
`default_nettype none
`include "cluster_config.svh"

module cluster_peripherals_asserts (
  input logic                      clk_i,
  input logic                      rst_i,
  input logic                      req_i,
  input logic                      r_valid_o,
  input logic                      eoc_o,
  input logic [`NB_CORES-1:0]      irq_req_o,
  input logic [`NB_CORES-1:0][4:0] irq_id_o
);

  // two register stages between request and response
  a_resp_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    r_valid_o == $past(req_i, 2))
    else $error("r_valid_o does not follow req_i by two cycles");

  for (genvar c = 0; c < `NB_CORES; c++) begin : g_irq_id
    a_irq_id_range: assert property (@(posedge clk_i) disable iff (rst_i)
      irq_req_o[c] |-> (irq_id_o[c] < `NB_EVENTS))
      else $error("irq id out of range on core %0d", c);
  end

  a_reset_state: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (!eoc_o && (irq_req_o == '0)))
    else $error("eoc or irq request high right after reset");

endmodule

bind cluster_peripherals cluster_peripherals_asserts asserts_i (
  .clk_i     ( clk_i     ),
  .rst_i     ( rst_i     ),
  .req_i     ( req_i     ),
  .r_valid_o ( r_valid_o ),
  .eoc_o     ( eoc_o     ),
  .irq_req_o ( irq_req_o ),
  .irq_id_o  ( irq_id_o  )
);

`default_nettype wire

// File: testbench/tb_cluster_peripherals.sv
// cluster peripherals testbench with clock, reset, bus access, directed tests and timeout
`timescale 1ns/100ps
`default_nettype none
`include "cluster_config.svh"

module tb_cluster_peripherals
  import periph_bus_pkg::*, cluster_event_pkg::*;
;

  localparam int TIMEOUT_CYCLES = 3000;
  localparam int IRQ_WAIT       = 100;
  localparam logic [3:0] SLOT_CTRL     = `TGT_CTRL;
  localparam logic [3:0] SLOT_TIMER    = `TGT_TIMER;
  localparam logic [3:0] SLOT_EU       = `TGT_EU;
  localparam logic [3:0] SLOT_UNMAPPED = 4'd3;

  logic                          clk_i;
  logic                          rst_i;
  logic                          req_i;
  logic [31:0]                   add_i;
  logic                          wen_i;
  logic [31:0]                   wdata_i;
  logic [3:0]                    be_i;
  logic [`ID_WIDTH-1:0]          id_i;
  logic                          r_valid_o;
  logic [31:0]                   r_rdata_o;
  logic                          r_opc_o;
  logic [`ID_WIDTH-1:0]          r_id_o;
  logic                          en_sa_boot_i;
  logic                          eoc_o;
  logic [`NB_CORES-1:0]          fetch_enable_o;
  logic [`NB_CORES-1:0][31:0]    boot_addr_o;
  logic [`NB_CORES-1:0]          dma_events_i;
  logic                          soc_evt_valid_i;
  logic [`SOC_EVT_WIDTH-1:0]     soc_evt_data_i;
  logic [`NB_CORES-1:0]          irq_req_o;
  logic [`NB_CORES-1:0][4:0]     irq_id_o;
  logic [`NB_CORES-1:0]          irq_ack_i;
  logic [`NB_CORES-1:0][4:0]     irq_ack_id_i;
  logic [`NB_CORES-1:0]          core_busy_i;
  logic [`NB_CORES-1:0]          core_clk_en_o;

  int                   errors = 0;
  int                   checks = 0;
  int                   cycle_cnt = 0;
  logic [`ID_WIDTH-1:0] next_id = '0;
  logic [31:0]          lcg_state = 32'd11;
  logic [31:0]          boot_m;
  // reference view of the event unit
  core_evt_t            pend_m [`NB_CORES];
  core_evt_t            mask_m [`NB_CORES];

  cluster_peripherals dut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] addr_of(input logic [3:0] slot, input logic [5:0] off);
    return 32'h1A100000 | {20'b0, slot, off, 2'b00};
  endfunction

  // bytes with a clear enable keep the old value
  function automatic logic [31:0] apply_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] keep;
    keep = ~{{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & keep) | (new_w & ~keep);
  endfunction

  // first set bit found when scanning upwards from bit 0
  function automatic logic [4:0] lowest_bit(input core_evt_t v);
    logic [4:0] id;
    logic       found;
    id    = '0;
    found = 1'b0;
    for (int e = 0; e < `NB_EVENTS; e++) begin
      if (v[e] && !found) begin
        id    = 5'(e);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  task automatic check_resp(input string msg, input periph_resp_t got, input periph_resp_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s, got rdata %h opc %b id %0d, expected rdata %h opc %b id %0d",
               $time, msg, got.rdata, got.opc, got.id, exp.rdata, exp.opc, exp.id);
      errors++;
    end
  endtask

  task automatic check_word(input string msg, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_evt(input string msg, input core_evt_t got, input core_evt_t exp);
    checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s, got %b expected %b", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("%-18s ok", name);
    end else begin
      $display("%-18s failed with %0d errors", name, errors - err_before);
    end
  endtask

  // entered on a falling edge, returns on the falling edge that shows the response
  task automatic bus_access(input logic write, input logic [3:0] slot, input logic [5:0] off,
                            input logic [31:0] data, input logic [3:0] be,
                            output periph_resp_t resp);
    req_i   = 1'b1;
    add_i   = addr_of(slot, off);
    wen_i   = ~write;
    wdata_i = data;
    be_i    = be;
    id_i    = next_id;
    @(negedge clk_i);
    req_i = 1'b0;
    @(negedge clk_i);
    if (r_valid_o !== 1'b1) begin
      $display("response for id %0d did not arrive two cycles after the request", next_id);
      errors++;
    end
    resp    = '{rdata: r_rdata_o, opc: r_opc_o, id: r_id_o};
    next_id = next_id + 1'b1;
  endtask

  task automatic write_reg(input logic [3:0] slot, input logic [5:0] off,
                           input logic [31:0] data, input logic [3:0] be);
    periph_resp_t got;
    periph_resp_t exp;
    exp = '{rdata: '0, opc: 1'b0, id: next_id};
    bus_access(1'b1, slot, off, data, be, got);
    check_resp($sformatf("write slot %0d offset %0d", slot, off), got, exp);
  endtask

  // status only, the caller judges the data
  task automatic read_word(input logic [3:0] slot, input logic [5:0] off,
                           output logic [31:0] data);
    periph_resp_t         got;
    logic [`ID_WIDTH-1:0] exp_id;
    exp_id = next_id;
    bus_access(1'b0, slot, off, '0, 4'hF, got);
    check_word($sformatf("read opc slot %0d offset %0d", slot, off), 32'(got.opc), 32'd0);
    check_word($sformatf("read id slot %0d offset %0d", slot, off), 32'(got.id), 32'(exp_id));
    data = got.rdata;
  endtask

  task automatic read_expect(input logic [3:0] slot, input logic [5:0] off,
                             input logic [31:0] exp_data, input string msg);
    periph_resp_t got;
    periph_resp_t exp;
    exp = '{rdata: exp_data, opc: 1'b0, id: next_id};
    bus_access(1'b0, slot, off, '0, 4'hF, got);
    check_resp(msg, got, exp);
  endtask

  task automatic read_pending(input int core);
    logic [31:0] w;
    read_word(SLOT_EU, 6'(4 + core), w);
    check_evt($sformatf("pending core %0d", core), w[`NB_EVENTS-1:0], pend_m[core]);
  endtask

  task automatic pulse_events(input logic [`NB_CORES-1:0] dma, input logic soc_v,
                              input logic [`SOC_EVT_WIDTH-1:0] soc_d);
    dma_events_i    = dma;
    soc_evt_valid_i = soc_v;
    soc_evt_data_i  = soc_d;
    @(negedge clk_i);
    dma_events_i    = '0;
    soc_evt_valid_i = 1'b0;
    for (int c = 0; c < `NB_CORES; c++) begin
      if (dma[c]) pend_m[c][EVT_DMA] = 1'b1;
      if (soc_v) pend_m[c][EVT_SOC] = 1'b1;
    end
  endtask

  task automatic ack_core(input int core, input logic [4:0] id);
    irq_ack_i[core]    = 1'b1;
    irq_ack_id_i[core] = id;
    @(negedge clk_i);
    irq_ack_i = '0;
    pend_m[core][id] = 1'b0;
  endtask

  task automatic check_irq_state(input string tag);
    logic [`NB_CORES-1:0] exp_req;
    core_evt_t            act;
    for (int c = 0; c < `NB_CORES; c++) begin
      act        = pend_m[c] & mask_m[c];
      exp_req[c] = |act;
      if (exp_req[c]) begin
        check_word($sformatf("%s irq id core %0d", tag, c), 32'(irq_id_o[c]),
                   32'(lowest_bit(act)));
      end
    end
    check_word({tag, " irq req"}, 32'(irq_req_o), 32'(exp_req));
    check_word({tag, " clock enable"}, 32'(core_clk_en_o), 32'(core_busy_i | exp_req));
  endtask

  task automatic wait_irq(input int core, output int at_cycle);
    int n;
    n = 0;
    while (irq_req_o[core] !== 1'b1 && n < IRQ_WAIT) begin
      @(negedge clk_i);
      n++;
    end
    if (irq_req_o[core] !== 1'b1) begin
      $display("no interrupt on core %0d within %0d cycles", core, IRQ_WAIT);
      errors++;
    end
    at_cycle = cycle_cnt;
  endtask

  task automatic ctrl_reset_write();
    int err0;
    err0 = errors;
    check_word("eoc after reset", 32'(eoc_o), 32'd0);
    check_word("fetch enable after reset", 32'(fetch_enable_o), 32'd0);
    for (int c = 0; c < `NB_CORES; c++) begin
      check_word($sformatf("boot addr core %0d", c), boot_addr_o[c], `BOOT_ADDR);
    end
    en_sa_boot_i = 1'b1;
    @(negedge clk_i);
    for (int c = 0; c < `NB_CORES; c++) begin
      check_word($sformatf("standalone boot core %0d", c), boot_addr_o[c], `ROM_BOOT_ADDR);
    end
    en_sa_boot_i = 1'b0;
    write_reg(SLOT_CTRL, 6'd1, 32'h0000000A, 4'b0001);
    check_word("fetch enable output", 32'(fetch_enable_o), 32'h0000000A);
    write_reg(SLOT_CTRL, 6'd0, 32'h00000001, 4'b0001);
    check_word("eoc output", 32'(eoc_o), 32'd1);
    // eoc holds when no byte is enabled
    write_reg(SLOT_CTRL, 6'd0, 32'h00000000, 4'b0000);
    check_word("eoc with be clear", 32'(eoc_o), 32'd1);
    read_expect(SLOT_CTRL, 6'd0, 32'd1, "eoc read back");
    read_expect(SLOT_CTRL, 6'd1, 32'h0000000A, "fetch enable read back");
    read_expect(SLOT_CTRL, 6'd2, `BOOT_ADDR, "boot addr read back");
    report_test("ctrl_reset_write", err0);
  endtask

  task automatic byte_enable_writes();
    int          err0;
    logic [3:0]  patterns [5];
    logic [31:0] data;
    err0 = errors;
    patterns = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};
    for (int i = 0; i < 5; i++) begin
      data = lcg_next();
      write_reg(SLOT_CTRL, 6'd2, data, patterns[i]);
      boot_m = apply_bytes(boot_m, data, patterns[i]);
      read_expect(SLOT_CTRL, 6'd2, boot_m, $sformatf("boot addr after be %b", patterns[i]));
      check_word("boot addr output", boot_addr_o[1], boot_m);
    end
    report_test("byte_enable_writes", err0);
  endtask

  task automatic timer_interrupt();
    int          err0;
    int          t0;
    int          t1;
    logic [31:0] cmp_val;
    logic [31:0] cnt_a;
    logic [31:0] cnt_b;
    err0 = errors;
    cmp_val = 32'd5 + (lcg_next() % 8);
    write_reg(SLOT_EU, 6'd0, 32'(1 << EVT_TIMER), 4'b0001);
    write_reg(SLOT_TIMER, 6'd1, cmp_val, 4'b1111);
    write_reg(SLOT_TIMER, 6'd2, 32'd1, 4'b0001);
    wait_irq(0, t0);
    ack_core(0, 5'(EVT_TIMER));
    check_word("timer irq after ack", 32'(irq_req_o[0]), 32'd0);
    for (int p = 0; p < 2; p++) begin
      wait_irq(0, t1);
      check_word("timer period", 32'(t1 - t0), cmp_val + 32'd1);
      ack_core(0, 5'(EVT_TIMER));
      t0 = t1;
    end
    write_reg(SLOT_TIMER, 6'd2, 32'd0, 4'b0001);
    read_word(SLOT_TIMER, 6'd0, cnt_a);
    read_word(SLOT_TIMER, 6'd0, cnt_b);
    check_word("counter stopped", cnt_b, cnt_a);
    for (int c = 1; c < `NB_CORES; c++) begin
      pend_m[c] = core_evt_t'(1 << EVT_TIMER);
      read_pending(c);
    end
    // clear every pending bit and mask before the event tests
    write_reg(SLOT_EU, 6'd0, 32'd0, 4'b0001);
    for (int c = 0; c < `NB_CORES; c++) begin
      write_reg(SLOT_EU, 6'(4 + c), 32'h7, 4'b0001);
      pend_m[c] = '0;
      mask_m[c] = '0;
    end
    check_irq_state("after timer cleanup");
    report_test("timer_interrupt", err0);
  endtask

  task automatic event_interrupts();
    int        err0;
    core_evt_t masks [`NB_CORES];
    err0 = errors;
    masks = '{3'b010, 3'b010, 3'b000, 3'b111};
    for (int c = 0; c < `NB_CORES; c++) begin
      write_reg(SLOT_EU, 6'(c), 32'(masks[c]), 4'b0001);
      mask_m[c] = masks[c];
    end
    core_busy_i = 4'b0100;
    pulse_events(4'b1111, 1'b0, '0);
    check_irq_state("dma events");
    core_busy_i = '0;
    @(negedge clk_i);
    check_irq_state("cores idle");
    write_reg(SLOT_EU, 6'd2, 32'h2, 4'b0001);
    mask_m[2] = 3'b010;
    check_irq_state("core 2 unmasked");
    ack_core(0, 5'(EVT_DMA));
    check_irq_state("ack core 0");
    read_pending(0);
    write_reg(SLOT_EU, 6'd5, 32'h2, 4'b0001);
    pend_m[1] = pend_m[1] & ~core_evt_t'(3'b010);
    check_irq_state("write clear core 1");
    read_pending(1);
    report_test("event_interrupts", err0);
  endtask

  task automatic soc_and_unmapped();
    int                        err0;
    logic [`SOC_EVT_WIDTH-1:0] soc_d;
    periph_resp_t              got;
    periph_resp_t              exp;
    err0 = errors;
    soc_d = lcg_next() >> 24;
    pulse_events('0, 1'b1, soc_d);
    check_irq_state("soc event");
    read_expect(SLOT_EU, 6'd8, 32'(soc_d), "soc data read back");
    for (int c = 0; c < `NB_CORES; c++) begin
      read_pending(c);
    end
    exp = '{rdata: '0, opc: 1'b1, id: next_id};
    bus_access(1'b0, SLOT_UNMAPPED, 6'd1, '0, 4'hF, got);
    check_resp("unmapped read", got, exp);
    exp.id = next_id;
    bus_access(1'b1, SLOT_UNMAPPED, 6'd1, 32'hFFFFFFFF, 4'hF, got);
    check_resp("unmapped write", got, exp);
    check_word("fetch enable untouched", 32'(fetch_enable_o), 32'h0000000A);
    report_test("soc_and_unmapped", err0);
  endtask

  task automatic back_to_back();
    int           err0;
    periph_req_t  reqs [5];
    periph_resp_t exps [5];
    periph_resp_t got;
    err0 = errors;
    reqs[0] = '{add: addr_of(SLOT_CTRL, 6'd2), wen: 1'b1, wdata: '0, be: 4'hF, id: 5'd16};
    reqs[1] = '{add: addr_of(SLOT_CTRL, 6'd1), wen: 1'b0, wdata: 32'h5, be: 4'h1, id: 5'd17};
    reqs[2] = '{add: addr_of(SLOT_CTRL, 6'd1), wen: 1'b1, wdata: '0, be: 4'hF, id: 5'd18};
    reqs[3] = '{add: addr_of(SLOT_EU, 6'd3), wen: 1'b1, wdata: '0, be: 4'hF, id: 5'd19};
    reqs[4] = '{add: addr_of(SLOT_UNMAPPED, 6'd0), wen: 1'b1, wdata: '0, be: 4'hF, id: 5'd20};
    exps[0] = '{rdata: boot_m, opc: 1'b0, id: 5'd16};
    exps[1] = '{rdata: '0, opc: 1'b0, id: 5'd17};
    // the read right behind the write sees the new value
    exps[2] = '{rdata: 32'h5, opc: 1'b0, id: 5'd18};
    exps[3] = '{rdata: 32'(mask_m[3]), opc: 1'b0, id: 5'd19};
    exps[4] = '{rdata: '0, opc: 1'b1, id: 5'd20};
    for (int i = 0; i < 7; i++) begin
      if (i >= 2) begin
        got = '{rdata: r_rdata_o, opc: r_opc_o, id: r_id_o};
        check_word($sformatf("valid for request %0d", i - 2), 32'(r_valid_o), 32'd1);
        check_resp($sformatf("pipelined response %0d", i - 2), got, exps[i - 2]);
      end
      if (i < 5) begin
        req_i   = 1'b1;
        add_i   = reqs[i].add;
        wen_i   = reqs[i].wen;
        wdata_i = reqs[i].wdata;
        be_i    = reqs[i].be;
        id_i    = reqs[i].id;
      end else begin
        req_i = 1'b0;
      end
      @(negedge clk_i);
    end
    check_word("valid after the burst", 32'(r_valid_o), 32'd0);
    report_test("back_to_back", err0);
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_i           = 1'b1;
    req_i           = 1'b0;
    add_i           = '0;
    wen_i           = 1'b1;
    wdata_i         = '0;
    be_i            = '0;
    id_i            = '0;
    en_sa_boot_i    = 1'b0;
    dma_events_i    = '0;
    soc_evt_valid_i = 1'b0;
    soc_evt_data_i  = '0;
    irq_ack_i       = '0;
    irq_ack_id_i    = '0;
    core_busy_i     = '0;
    boot_m          = `BOOT_ADDR;
    for (int c = 0; c < `NB_CORES; c++) begin
      pend_m[c] = '0;
      mask_m[c] = '0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    ctrl_reset_write();
    byte_enable_writes();
    timer_interrupt();
    event_interrupts();
    soc_and_unmapped();
    back_to_back();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/periph_bus_pkg.sv
common/cluster_event_pkg.sv
logic/pipe_reg.sv
logic/speriph_router.sv
control_unit/cluster_control_unit.sv
timer/cluster_timer.sv
event_unit/event_unit.sv
logic/cluster_peripherals.sv
testbench/cluster_peripherals_asserts.sv
testbench/tb_cluster_peripherals.sv
